//--- source/cache_dram_subsystem.sv
// top of the cache-miss path, four cache DMA lanes sharing one channel memory
`default_nettype none

`include "dram_macros.svh"

module cache_dram_subsystem (
  input  wire logic                                                  core_clk,
  input  wire logic                                                  reset_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                            dma_pkt_v_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                            dma_pkt_write_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0][`DRAM_CACHE_ADDR_WIDTH-1:0] dma_pkt_addr_i,
  output logic [`DRAM_NUM_CACHE-1:0]                                 dma_pkt_yumi_o,
  input  wire logic [`DRAM_NUM_CACHE-1:0][`DRAM_DATA_WIDTH-1:0]       dma_data_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                            dma_data_v_i,
  output logic [`DRAM_NUM_CACHE-1:0]                                 dma_data_yumi_o,
  output logic [`DRAM_DATA_WIDTH-1:0]                                dma_data_o,
  output logic [`DRAM_NUM_CACHE-1:0]                                 dma_data_v_o,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                            dma_data_ready_i
);

  logic grant_v;
  logic [`DRAM_CACHE_ID_WIDTH-1:0] grant_id;
  logic accept;

  logic req_v;
  logic req_write;
  dram_addr_pkg::dram_ch_addr_u req_ch_addr;
  logic [`DRAM_DATA_WIDTH-1:0] req_data;
  logic req_yumi;

  logic rd_v;
  logic [`DRAM_DATA_WIDTH-1:0] rd_data;
  dram_addr_pkg::dram_ch_addr_u rd_ch_addr;
  logic rd_ready;

  dma_rr_arbiter arb_i (
    .core_clk   (core_clk),
    .reset_i    (reset_i),
    .req_i      (dma_pkt_v_i),
    .accept_i   (accept),
    .grant_v_o  (grant_v),
    .grant_id_o (grant_id),
    .yumi_o     (dma_pkt_yumi_o)
  );

  // winning lane's packet fields go to the bridge
  cache_to_dram bridge_i (
    .core_clk          (core_clk),
    .reset_i           (reset_i),
    .grant_v_i         (grant_v),
    .grant_id_i        (grant_id),
    .pkt_write_i       (dma_pkt_write_i[grant_id]),
    .pkt_addr_i        (dma_pkt_addr_i[grant_id]),
    .accept_o          (accept),
    .cache_data_i      (dma_data_i),
    .cache_data_v_i    (dma_data_v_i),
    .cache_data_yumi_o (dma_data_yumi_o),
    .fill_data_o       (dma_data_o),
    .fill_v_o          (dma_data_v_o),
    .fill_ready_i      (dma_data_ready_i),
    .req_v_o           (req_v),
    .req_write_o       (req_write),
    .req_ch_addr_o     (req_ch_addr),
    .req_data_o        (req_data),
    .req_yumi_i        (req_yumi),
    .rd_v_i            (rd_v),
    .rd_data_i         (rd_data),
    .rd_ch_addr_i      (rd_ch_addr),
    .rd_ready_o        (rd_ready)
  );

  dram_channel_mem mem_i (
    .core_clk      (core_clk),
    .reset_i       (reset_i),
    .req_v_i       (req_v),
    .req_write_i   (req_write),
    .req_ch_addr_i (req_ch_addr),
    .req_data_i    (req_data),
    .req_yumi_o    (req_yumi),
    .rd_v_o        (rd_v),
    .rd_data_o     (rd_data),
    .rd_ch_addr_o  (rd_ch_addr),
    .rd_ready_i    (rd_ready)
  );

endmodule

`default_nettype wire

//--- source/cache_to_dram.sv
// turns one granted block packet into word requests and steers fill data back to its cache
`default_nettype none

`include "dram_macros.svh"

module cache_to_dram (
  input  wire logic                                            core_clk,
  input  wire logic                                            reset_i,
  input  wire logic                                            grant_v_i,
  input  wire logic [`DRAM_CACHE_ID_WIDTH-1:0]                 grant_id_i,
  input  wire logic                                            pkt_write_i,
  input  wire logic [`DRAM_CACHE_ADDR_WIDTH-1:0]               pkt_addr_i,
  output logic                                                 accept_o,
  input  wire logic [`DRAM_NUM_CACHE-1:0][`DRAM_DATA_WIDTH-1:0] cache_data_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                      cache_data_v_i,
  output logic [`DRAM_NUM_CACHE-1:0]                           cache_data_yumi_o,
  output logic [`DRAM_DATA_WIDTH-1:0]                          fill_data_o,
  output logic [`DRAM_NUM_CACHE-1:0]                           fill_v_o,
  input  wire logic [`DRAM_NUM_CACHE-1:0]                      fill_ready_i,
  output logic                                                 req_v_o,
  output logic                                                 req_write_o,
  output dram_addr_pkg::dram_ch_addr_u                         req_ch_addr_o,
  output logic [`DRAM_DATA_WIDTH-1:0]                          req_data_o,
  input  wire logic                                            req_yumi_i,
  input  wire logic                                            rd_v_i,
  input  wire logic [`DRAM_DATA_WIDTH-1:0]                     rd_data_i,
  input  wire dram_addr_pkg::dram_ch_addr_u                    rd_ch_addr_i,
  output logic                                                 rd_ready_o
);

  localparam int ID_W = `DRAM_CACHE_ID_WIDTH;
  localparam int RO_W = `DRAM_RO_WIDTH;
  localparam int CO_W = `DRAM_CO_WIDTH;
  localparam int NUM_CACHE = `DRAM_NUM_CACHE;

  logic busy_r;
  logic write_r;
  logic [ID_W-1:0] owner_r;
  logic [RO_W-1:0] block_r;
  logic [CO_W-1:0] cnt_r;
  logic [CO_W:0] issue_cnt_r;
  logic take;
  logic wr_fire;
  logic rd_issue;
  logic rd_fire;
  logic last_word;
  logic [ID_W-1:0] rd_owner;

  // no packet is taken while reset is held
  assign accept_o = ~busy_r & ~reset_i;
  assign take = grant_v_i & accept_o;

  // evict words go straight from the owner lane to the channel
  assign req_write_o = write_r;
  assign req_data_o = cache_data_i[owner_r];

  always_comb begin
    if (write_r) begin
      req_v_o = busy_r & cache_data_v_i[owner_r];
    end else begin
      req_v_o = busy_r & (issue_cnt_r != (CO_W + 1)'(`DRAM_BLOCK_WORDS));
    end
  end

  // owner id picks bank group and bank, block index picks the row
  always_comb begin
    req_ch_addr_o = '0;
    {req_ch_addr_o.cache_order.bg, req_ch_addr_o.cache_order.ba} = owner_r;
    req_ch_addr_o.cache_order.ro = block_r;
    req_ch_addr_o.cache_order.co = write_r ? cnt_r : issue_cnt_r[CO_W-1:0];
  end

  assign wr_fire = busy_r & write_r & req_v_o & req_yumi_i;
  assign rd_issue = busy_r & ~write_r & req_v_o & req_yumi_i;

  always_comb begin
    cache_data_yumi_o = '0;
    if (wr_fire) begin
      cache_data_yumi_o[owner_r] = 1'b1;
    end
  end

  // returned address names the cache that asked
  assign rd_owner = {rd_ch_addr_i.cache_order.bg, rd_ch_addr_i.cache_order.ba};
  assign fill_data_o = rd_data_i;

  always_comb begin
    for (int i = 0; i < NUM_CACHE; i++) begin
      fill_v_o[i] = rd_v_i & (rd_owner == ID_W'(i));
    end
  end

  assign rd_ready_o = fill_ready_i[owner_r];
  assign rd_fire = busy_r & ~write_r & rd_v_i & rd_ready_o;

  assign last_word = (wr_fire | rd_fire) & (cnt_r == CO_W'(`DRAM_BLOCK_WORDS - 1));

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      write_r <= 1'b0;
      owner_r <= '0;
      cnt_r <= '0;
      issue_cnt_r <= '0;
    end else if (take) begin
      busy_r <= 1'b1;
      write_r <= pkt_write_i;
      owner_r <= grant_id_i;
      cnt_r <= '0;
      issue_cnt_r <= '0;
    end else begin
      if (wr_fire | rd_fire) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (rd_issue) begin
        issue_cnt_r <= issue_cnt_r + 1'b1;
      end
      if (last_word) begin
        busy_r <= 1'b0;
      end
    end
  end

  // bits above the block index are dropped, so blocks alias
  always_ff @(posedge core_clk) begin
    if (take) begin
      block_r <= pkt_addr_i[`DRAM_BLOCK_LSB +: RO_W];
    end
  end

endmodule

`default_nettype wire

//--- source/dma_rr_arbiter.sv
// round-robin pick of one cache DMA packet per transaction, with per-lane yumi
`default_nettype none

`include "dram_macros.svh"

module dma_rr_arbiter (
  input  wire logic                             core_clk,
  input  wire logic                             reset_i,
  input  wire logic [`DRAM_NUM_CACHE-1:0]       req_i,
  input  wire logic                             accept_i,
  output logic                                  grant_v_o,
  output logic [`DRAM_CACHE_ID_WIDTH-1:0]       grant_id_o,
  output logic [`DRAM_NUM_CACHE-1:0]            yumi_o
);

  localparam int NUM_CACHE = `DRAM_NUM_CACHE;
  localparam int ID_W = `DRAM_CACHE_ID_WIDTH;

  logic [ID_W-1:0] last_r;
  logic [ID_W-1:0] cand;
  logic found;
  logic take;

  // search starts one past the last winner and wraps
  always_comb begin
    found = 1'b0;
    cand = '0;
    grant_id_o = '0;
    for (int i = 1; i <= NUM_CACHE; i++) begin
      cand = last_r + ID_W'(i);
      if (!found && req_i[cand]) begin
        found = 1'b1;
        grant_id_o = cand;
      end
    end
  end

  assign grant_v_o = found;
  assign take = grant_v_o & accept_i;

  always_comb begin
    yumi_o = '0;
    if (take) begin
      yumi_o[grant_id_o] = 1'b1;
    end
  end

  // pointer parks on the last cache so cache 0 wins first
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      last_r <= ID_W'(NUM_CACHE - 1);
    end else if (take) begin
      last_r <= grant_id_o;
    end
  end

endmodule

`default_nettype wire

//--- source/dram_addr_pkg.sv
// channel-address word with the bridge and the memory model views of its fields
`default_nettype none

`include "dram_macros.svh"

package dram_addr_pkg;

  // one 11-bit word, two decodes
  typedef union packed {
    // bridge side, owner id sits on top
    struct packed {
      logic [`DRAM_BG_WIDTH-1:0] bg;
      logic [`DRAM_BA_WIDTH-1:0] ba;
      logic [`DRAM_RO_WIDTH-1:0] ro;
      logic [`DRAM_CO_WIDTH-1:0] co;
      logic [`DRAM_BYTE_OFFSET_WIDTH-1:0] byte_offset;
    } cache_order;
    // memory side, row bits lead
    struct packed {
      logic [`DRAM_RO_WIDTH-1:0] ro;
      logic [`DRAM_BG_WIDTH-1:0] bg;
      logic [`DRAM_BA_WIDTH-1:0] ba;
      logic [`DRAM_CO_WIDTH-1:0] co;
      logic [`DRAM_BYTE_OFFSET_WIDTH-1:0] byte_offset;
    } sim_order;
  } dram_ch_addr_u;

endpackage

`default_nettype wire

//--- source/dram_channel_mem.sv
// behavioral channel memory with fixed read latency, used as the DRAM end of the subsystem
`default_nettype none

`include "dram_macros.svh"

module dram_channel_mem (
  input  wire logic                         core_clk,
  input  wire logic                         reset_i,
  input  wire logic                         req_v_i,
  input  wire logic                         req_write_i,
  input  wire dram_addr_pkg::dram_ch_addr_u req_ch_addr_i,
  input  wire logic [`DRAM_DATA_WIDTH-1:0]  req_data_i,
  output logic                              req_yumi_o,
  output logic                              rd_v_o,
  output logic [`DRAM_DATA_WIDTH-1:0]       rd_data_o,
  output dram_addr_pkg::dram_ch_addr_u      rd_ch_addr_o,
  input  wire logic                         rd_ready_i
);

  localparam int LAT = `DRAM_READ_LATENCY;
  localparam int IDX_W = `DRAM_CH_ADDR_WIDTH - `DRAM_BYTE_OFFSET_WIDTH;
  localparam int WORDS = 1 << IDX_W;

  logic [`DRAM_DATA_WIDTH-1:0] mem [WORDS];
  logic [LAT-1:0] pipe_v_r;
  dram_addr_pkg::dram_ch_addr_u pipe_addr_r [LAT];
  logic stall;
  logic rd_take;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // storage is indexed through the memory-side field order
  function automatic logic [IDX_W-1:0] mem_index(input dram_addr_pkg::dram_ch_addr_u a);
    return {a.sim_order.ro, a.sim_order.bg, a.sim_order.ba, a.sim_order.co};
  endfunction

  // head of the pipe waiting on the bridge freezes everything
  assign stall = rd_v_o & ~rd_ready_i;
  assign rd_take = req_v_i & ~req_write_i & ~stall;
  assign req_yumi_o = req_v_i & (req_write_i | ~stall);

  assign wr_idx = mem_index(req_ch_addr_i);
  assign rd_idx = mem_index(rd_ch_addr_o);

  assign rd_v_o = pipe_v_r[LAT-1];
  assign rd_ch_addr_o = pipe_addr_r[LAT-1];
  assign rd_data_o = mem[rd_idx];

  always_ff @(posedge core_clk) begin
    if (req_v_i && req_write_i) begin
      mem[wr_idx] <= req_data_i;
    end
  end

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      pipe_v_r <= '0;
    end else if (!stall) begin
      pipe_v_r <= {pipe_v_r[LAT-2:0], rd_take};
    end
  end

  // address rides along with its valid bit
  always_ff @(posedge core_clk) begin
    if (!stall) begin
      pipe_addr_r[0] <= req_ch_addr_i;
      for (int i = 1; i < LAT; i++) begin
        pipe_addr_r[i] <= pipe_addr_r[i-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/dram_macros.svh
// shared sizing for the cache-to-DRAM subsystem, included by every design and test file
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// caches sharing the one channel
`define DRAM_NUM_CACHE 4
`define DRAM_CACHE_ID_WIDTH 2

// one word per DRAM beat
`define DRAM_DATA_WIDTH 32
`define DRAM_BLOCK_WORDS 8

// byte address carried in a DMA packet
`define DRAM_CACHE_ADDR_WIDTH 12

// channel address fields
`define DRAM_BG_WIDTH 1
`define DRAM_BA_WIDTH 1
`define DRAM_RO_WIDTH 4
`define DRAM_CO_WIDTH 3
`define DRAM_BYTE_OFFSET_WIDTH 2
`define DRAM_CH_ADDR_WIDTH 11

// block index starts above the word and byte offsets
`define DRAM_BLOCK_LSB 5

// cycles from an accepted read to its data
`define DRAM_READ_LATENCY 3

`endif

//--- tb/tb_cache_dram_subsystem.sv
// testbench for cache_dram_subsystem, drives four cache DMA lanes and checks every fill word
`default_nettype none

`include "dram_macros.svh"

module tb_cache_dram_subsystem;

  localparam int NUM_CACHE = `DRAM_NUM_CACHE;
  localparam int WORDS = `DRAM_BLOCK_WORDS;
  localparam int AW = `DRAM_CACHE_ADDR_WIDTH;
  localparam int DW = `DRAM_DATA_WIDTH;
  localparam int IDX_W = `DRAM_CH_ADDR_WIDTH - `DRAM_BYTE_OFFSET_WIDTH;

  logic core_clk = 1'b0;
  logic reset_i;
  logic [NUM_CACHE-1:0] dma_pkt_v_i;
  logic [NUM_CACHE-1:0] dma_pkt_write_i;
  logic [NUM_CACHE-1:0][AW-1:0] dma_pkt_addr_i;
  logic [NUM_CACHE-1:0] dma_pkt_yumi_o;
  logic [NUM_CACHE-1:0][DW-1:0] dma_data_i;
  logic [NUM_CACHE-1:0] dma_data_v_i;
  logic [NUM_CACHE-1:0] dma_data_yumi_o;
  logic [DW-1:0] dma_data_o;
  logic [NUM_CACHE-1:0] dma_data_v_o;
  logic [NUM_CACHE-1:0] dma_data_ready_i;

  // expected memory contents, one word per cache, block and column
  logic [DW-1:0] shadow [1 << IDX_W];
  logic [31:0] lcg_state = 32'd25;
  logic random_ready;
  logic [NUM_CACHE-1:0] fill_open;
  logic [AW-1:0] fill_addr [NUM_CACHE];
  int fill_col [NUM_CACHE];
  int grant_order [$];
  int txn_issued;
  int cycle_count;

  cache_dram_subsystem dut_i (
    .core_clk         (core_clk),
    .reset_i          (reset_i),
    .dma_pkt_v_i      (dma_pkt_v_i),
    .dma_pkt_write_i  (dma_pkt_write_i),
    .dma_pkt_addr_i   (dma_pkt_addr_i),
    .dma_pkt_yumi_o   (dma_pkt_yumi_o),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

  always #5 core_clk = ~core_clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // cache id on the bank bits, block index on the row, word on the column
  function automatic int shadow_index(input int id, input logic [AW-1:0] addr, input int col);
    dram_addr_pkg::dram_ch_addr_u a;
    a = '0;
    {a.cache_order.bg, a.cache_order.ba} = `DRAM_CACHE_ID_WIDTH'(id);
    a.cache_order.ro = addr[`DRAM_BLOCK_LSB +: `DRAM_RO_WIDTH];
    a.cache_order.co = `DRAM_CO_WIDTH'(col);
    return int'(a[`DRAM_CH_ADDR_WIDTH-1:`DRAM_BYTE_OFFSET_WIDTH]);
  endfunction

  function automatic logic [DW-1:0] expected_fill(input int id, input logic [AW-1:0] addr,
                                                  input int col);
    return shadow[shadow_index(id, addr, col)];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_idle_outputs();
    assert (dma_pkt_yumi_o === '0) else abort_run($sformatf(
      "mismatch at time %0t: dma_pkt_yumi_o expected %b got %b", $time, 4'b0, dma_pkt_yumi_o));
    assert (dma_data_yumi_o === '0) else abort_run($sformatf(
      "mismatch at time %0t: dma_data_yumi_o expected %b got %b", $time, 4'b0, dma_data_yumi_o));
    assert (dma_data_v_o === '0) else abort_run($sformatf(
      "mismatch at time %0t: dma_data_v_o expected %b got %b", $time, 4'b0, dma_data_v_o));
  endtask

  // entered and left 1 unit after a rising edge
  task automatic send_packet(input int id, input logic wr, input logic [AW-1:0] addr);
    dma_pkt_v_i[id] = 1'b1;
    dma_pkt_write_i[id] = wr;
    dma_pkt_addr_i[id] = addr;
    txn_issued++;
    @(negedge core_clk);
    while (!dma_pkt_yumi_o[id]) @(negedge core_clk);
    @(posedge core_clk);
    #1;
    dma_pkt_v_i[id] = 1'b0;
  endtask

  task automatic write_block(input int id, input logic [AW-1:0] addr);
    logic [DW-1:0] w;
    send_packet(id, 1'b1, addr);
    for (int col = 0; col < WORDS; col++) begin
      w = next_rand();
      dma_data_i[id] = w;
      dma_data_v_i[id] = 1'b1;
      @(negedge core_clk);
      while (!dma_data_yumi_o[id]) @(negedge core_clk);
      shadow[shadow_index(id, addr, col)] = w;
      @(posedge core_clk);
      #1;
    end
    dma_data_v_i[id] = 1'b0;
  endtask

  // checker counts the words while this task opens and closes the fill
  task automatic fill_block(input int id, input logic [AW-1:0] addr);
    fill_addr[id] = addr;
    fill_col[id] = 0;
    fill_open[id] = 1'b1;
    send_packet(id, 1'b0, addr);
    while (fill_col[id] < WORDS) @(posedge core_clk);
    #1;
    fill_open[id] = 1'b0;
  endtask

  task automatic check_grant_order(input int e0, input int e1, input int e2, input int e3);
    int want [4];
    want = '{e0, e1, e2, e3};
    assert (grant_order.size() == 4) else abort_run($sformatf(
      "expected four packet grants but saw %0d", grant_order.size()));
    for (int k = 0; k < 4; k++) begin
      assert (grant_order[k] == want[k]) else abort_run($sformatf(
        "mismatch at time %0t: dma_pkt_yumi_o grant %0d expected cache %0d got cache %0d",
        $time, k, want[k], grant_order[k]));
    end
    grant_order.delete();
  endtask

  // ready toggles 1 unit after the edge
  always @(posedge core_clk) begin
    #1;
    for (int i = 0; i < NUM_CACHE; i++) begin
      dma_data_ready_i[i] = random_ready ? (next_rand() >> 16) % 4 != 0 : 1'b1;
    end
  end

  always @(negedge core_clk) begin
    if (!reset_i) begin
      for (int i = 0; i < NUM_CACHE; i++) begin
        if (dma_pkt_yumi_o[i]) begin
          grant_order.push_back(i);
        end
      end
    end
  end

  // fill words compared in column order as they transfer
  always @(negedge core_clk) begin
    logic [DW-1:0] want;
    if (!reset_i) begin
      for (int i = 0; i < NUM_CACHE; i++) begin
        if (dma_data_v_o[i] && dma_data_ready_i[i]) begin
          assert (fill_open[i] && fill_col[i] < WORDS) else abort_run($sformatf(
            "cache %0d received a fill word at time %0t with no fill pending", i, $time));
          want = expected_fill(i, fill_addr[i], fill_col[i]);
          assert (dma_data_o === want) else abort_run($sformatf(
            "mismatch at time %0t: dma_data_o expected %h got %h (cache %0d column %0d)",
            $time, want, dma_data_o, i, fill_col[i]));
          fill_col[i]++;
        end
      end
    end
  end

  always @(posedge core_clk) begin
    cycle_count++;
    if (cycle_count > 40 * txn_issued + 100) begin
      abort_run($sformatf("timeout after %0d cycles with %0d transactions issued",
                          cycle_count, txn_issued));
    end
  end

  initial begin
    reset_i = 1'b1;
    // requests held up by reset must not be taken
    dma_pkt_v_i = '1;
    dma_pkt_write_i = '0;
    dma_pkt_addr_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '1;
    dma_data_ready_i = '0;
    random_ready = 1'b0;
    fill_open = '0;
    txn_issued = 0;
    cycle_count = 0;
    for (int i = 0; i < NUM_CACHE; i++) begin
      fill_col[i] = 0;
      fill_addr[i] = '0;
    end

    repeat (5) begin
      @(posedge core_clk);
      #1;
      check_idle_outputs();
    end
    reset_i = 1'b0;
    dma_pkt_v_i = '0;
    dma_data_v_i = '0;
    @(negedge core_clk);
    check_idle_outputs();
    @(posedge core_clk);
    #1;

    // all four lanes at once on the same block index
    fork
      write_block(0, 12'h060);
      write_block(1, 12'h060);
      write_block(2, 12'h060);
      write_block(3, 12'h060);
    join
    check_grant_order(0, 1, 2, 3);
    fork
      fill_block(0, 12'h060);
      fill_block(1, 12'h060);
      fill_block(2, 12'h060);
      fill_block(3, 12'h060);
    join
    check_grant_order(0, 1, 2, 3);

    // cache 1 wins alone, so the next round starts at cache 2
    write_block(1, 12'h0a0);
    grant_order.delete();
    fork
      fill_block(0, 12'h060);
      fill_block(1, 12'h060);
      fill_block(2, 12'h060);
      fill_block(3, 12'h060);
    join
    check_grant_order(2, 3, 0, 1);

    write_block(0, 12'h0e0);
    fill_block(0, 12'h0e0);

    // upper address bits alias onto block 4
    write_block(2, 12'h080);
    fill_block(2, 12'ha80);

    random_ready = 1'b1;
    fork
      fill_block(0, 12'h0e0);
      fill_block(1, 12'h0a0);
      fill_block(2, 12'h680);
      fill_block(3, 12'h060);
    join
    write_block(3, 12'h1e0);
    fill_block(3, 12'h1e0);
    random_ready = 1'b0;

    // stray words would still hit the checker here
    repeat (10) @(posedge core_clk);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/dram_addr_pkg.sv
source/dma_rr_arbiter.sv
source/cache_to_dram.sv
source/dram_channel_mem.sv
source/cache_dram_subsystem.sv
tb/tb_cache_dram_subsystem.sv
